/* flist.f */
source/cache_pkg.sv
source/mem_req_if.sv
source/cache_if.sv
source/cache_controller.sv
source/cache_array.sv
source/mem_dispatch.sv
source/mem_bank.sv
source/mem_collect.sv
source/cache_top.sv
tb/cache_top_tb.sv

/* Bender.yml */
package:
  name: cache_top

sources:
  - source/cache_pkg.sv
  - source/mem_req_if.sv
  - source/cache_if.sv
  - source/cache_controller.sv
  - source/cache_array.sv
  - source/mem_dispatch.sv
  - source/mem_bank.sv
  - source/mem_collect.sv
  - source/cache_top.sv
  - target: test
    files:
      - tb/cache_top_tb.sv

/* tb/cache_top_tb.sv */
`timescale 1ns/1ps

module cache_top_tb;
	import cache_pkg::*;

	localparam int TIMEOUT = 200; // Cycles allowed for one access

	logic  clk;
	logic  arst_n;
	addr_t addr;
	word_t data_in;
	logic  rd;
	logic  wr;
	word_t data_out;
	logic  done;
	logic  hit;
	logic  err;

	word_t shadow [addr_t]; // Reference memory, keyed by word address
	int    errors;
	int    errors_at_start;
	int    tests;
	word_t got_data;
	logic  got_hit;
	int    got_lat;        // Falling edges from strobe to done

	cache_top cache_top_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.addr     (addr),
		.data_in  (data_in),
		.rd       (rd),
		.wr       (wr),
		.data_out (data_out),
		.done     (done),
		.hit      (hit),
		.err      (err)
	);

	always #50 clk = ~clk;

	err_follows_illegal: assert property (@(posedge clk) disable iff (!arst_n)
		(rd && wr) |=> err) else begin
		errors++;
		$display("Error at %0t: err missing after a strobe with rd and wr", $time);
	end

	err_only_when_illegal: assert property (@(posedge clk) disable iff (!arst_n)
		err |-> $past(rd && wr)) else begin
		errors++;
		$display("Error at %0t: err raised without an illegal strobe", $time);
	end

	hit_only_with_done: assert property (@(posedge clk) disable iff (!arst_n)
		hit |-> done) else begin
		errors++;
		$display("Error at %0t: hit high outside done", $time);
	end

	function automatic addr_t word_key(input addr_t a);
		return {a[15:1], 1'b0}; // Byte bit 0 is ignored
	endfunction

	function automatic word_t shadow_read(input addr_t a);
		if (shadow.exists(word_key(a)))
			return shadow[word_key(a)];
		return '0; // Memory starts all zero
	endfunction

	// One request strobe, then wait for done
	task automatic run_access(input logic is_wr, input addr_t a, input word_t d);
		@(negedge clk);
		addr    = a;
		data_in = d;
		rd      = !is_wr;
		wr      = is_wr;
		if (is_wr)
			shadow[word_key(a)] = d;
		@(negedge clk);
		rd      = 1'b0;
		wr      = 1'b0;
		got_lat = 1;
		while (!done && got_lat < TIMEOUT) begin
			@(negedge clk);
			got_lat++;
		end
		if (!done) begin
			$display("Timeout: no done within %0d cycles of the request to %h", TIMEOUT, a);
			$display("Errors found");
			$finish;
		end else begin
			got_data = data_out;
			got_hit  = hit;
		end
	endtask

	// hit_exp below zero means the hit flag is not checked
	task automatic check_read(input addr_t a, input int hit_exp);
		word_t expected;
		expected = shadow_read(a);
		run_access(1'b0, a, '0);
		assert (got_data === expected) else begin
			errors++;
			$display("Error at %0t: read %h gave %h, expected %h", $time, a, got_data, expected);
		end
		if (hit_exp >= 0) begin
			assert (got_hit === hit_exp[0]) else begin
				errors++;
				$display("Error at %0t: read %h hit %b, expected %0d", $time, a, got_hit, hit_exp);
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("Test %0d %s: %s", tests, name, (errors == errors_at_start) ? "pass" : "FAIL");
		errors_at_start = errors;
	endtask

	initial begin
		addr_t ra;
		logic  rw;
		void'($urandom(32'hff2ed85d));
		clk             = 1'b0;
		arst_n          = 1'b0;
		addr            = '0;
		data_in         = '0;
		rd              = 1'b0;
		wr              = 1'b0;
		errors          = 0;
		errors_at_start = 0;
		tests           = 0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;

		check_read(16'h0a18, 0);
		finish_test("read miss on empty cache");

		run_access(1'b1, 16'h0410, 16'hbeef);
		check_read(16'h0410, 1);
		assert (got_lat == 2) else begin
			errors++;
			$display("Error at %0t: hit latency %0d, expected 2", $time, got_lat);
		end
		finish_test("write then read hit");

		run_access(1'b1, 16'h1208, 16'h5a5a);
		check_read(16'h3408, 0); // Same index, evicts the dirty line
		check_read(16'h1208, 0); // Data must come back from memory
		finish_test("dirty eviction");

		for (int w = 0; w < 4; w++)
			run_access(1'b1, addr_t'(16'h2028 + 2 * w), word_t'(16'hc000 + w));
		for (int w = 0; w < 4; w++)
			check_read(addr_t'(16'h2028 + 2 * w), 1);
		finish_test("all four word offsets");

		@(negedge clk);
		addr = 16'h0040;
		rd   = 1'b1;
		wr   = 1'b1;
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
		assert (err === 1'b1) else begin
			errors++;
			$display("Error at %0t: err not high one cycle after the strobe", $time);
		end
		for (int i = 0; i < 10; i++) begin
			assert (done === 1'b0) else begin
				errors++;
				$display("Error at %0t: done after an illegal request", $time);
			end
			@(negedge clk);
		end
		finish_test("illegal request");

		for (int n = 0; n < 200; n++) begin
			ra = {tag_t'($urandom_range(3) * 8'h11), index_t'($urandom_range(3)),
				word_sel_t'($urandom_range(3)), 1'($urandom_range(1))};
			rw = 1'($urandom_range(1));
			if (rw)
				run_access(1'b1, ra, word_t'($urandom));
			else
				check_read(ra, -1);
		end
		finish_test("random reads and writes");

		$display("Tests run: %0d, failed checks: %0d", tests, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* source/cache_top.sv */
`timescale 1ns/1ps

module cache_top (
	input  logic              clk,
	input  logic              arst_n,
	input  cache_pkg::addr_t  addr,
	input  cache_pkg::word_t  data_in,
	input  logic              rd,
	input  logic              wr,
	output cache_pkg::word_t  data_out,
	output logic              done,
	output logic              hit,
	output logic              err
);
	import cache_pkg::*;

	cache_if   cache_bus ();
	mem_req_if ctrl_req ();
	mem_req_if bank_req [NUM_BANKS] ();

	logic  bank_rvalid [NUM_BANKS];
	word_t bank_rdata  [NUM_BANKS];
	word_t fill_data;
	logic  fill_valid;

	cache_controller ctrl_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.addr       (addr),
		.data_in    (data_in),
		.rd         (rd),
		.wr         (wr),
		.data_out   (data_out),
		.done       (done),
		.hit        (hit),
		.err        (err),
		.cache      (cache_bus),
		.mem        (ctrl_req),
		.fill_data  (fill_data),
		.fill_valid (fill_valid)
	);

	cache_array array_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.port   (cache_bus)
	);

	mem_dispatch dispatch_inst (
		.up   (ctrl_req),
		.down (bank_req)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_mem
		mem_bank #(
			.LATENCY (MEM_LATENCY)
		) bank_inst (
			.clk    (clk),
			.arst_n (arst_n),
			.req    (bank_req[i]),
			.rvalid (bank_rvalid[i]),
			.rdata  (bank_rdata[i])
		);
	end

	mem_collect collect_inst (
		.rvalid_bank (bank_rvalid),
		.rdata_bank  (bank_rdata),
		.fill_valid  (fill_valid),
		.fill_data   (fill_data)
	);

endmodule

/* source/mem_collect.sv */
`timescale 1ns/1ps

module mem_collect (
	input  logic              rvalid_bank [cache_pkg::NUM_BANKS],
	input  cache_pkg::word_t  rdata_bank  [cache_pkg::NUM_BANKS],
	output logic              fill_valid,
	output cache_pkg::word_t  fill_data
);
	import cache_pkg::*;

	// Reads go out one bank per cycle, so returns never overlap
	always_comb begin
		fill_valid = 1'b0;
		fill_data  = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (rvalid_bank[i]) begin
				fill_valid = 1'b1;
				fill_data  = rdata_bank[i];
			end
		end
	end

endmodule

/* source/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank #(
	parameter int LATENCY = cache_pkg::MEM_LATENCY
) (
	input  logic              clk,
	input  logic              arst_n,
	mem_req_if.memory         req,
	output logic              rvalid,
	output cache_pkg::word_t  rdata
);
	import cache_pkg::*;

	word_t                         mem [2 ** $bits(bank_addr_t)] = '{default: '0};
	bank_addr_t                    baddr;
	logic  [LATENCY-1:0]           valid_pipe;
	word_t [LATENCY-1:0]           data_pipe;

	assign baddr = bank_addr_t'(req.addr >> WSEL_W); // Drop the bank select

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= req.rd;
			for (int i = 1; i < LATENCY; i++)
				valid_pipe[i] <= valid_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (req.wr)
			mem[baddr] <= req.wdata;
		data_pipe[0] <= mem[baddr];
		for (int i = 1; i < LATENCY; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign rvalid = valid_pipe[LATENCY-1];
	assign rdata  = data_pipe[LATENCY-1];

endmodule

/* source/mem_dispatch.sv */
`timescale 1ns/1ps

module mem_dispatch (
	mem_req_if.memory    up,
	mem_req_if.requester down [cache_pkg::NUM_BANKS]
);
	import cache_pkg::*;

	word_sel_t sel;

	assign sel = up.addr[WSEL_W-1:0]; // Word offset picks the bank

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		logic picked;

		assign picked         = (sel == i);
		assign down[i].rd     = up.rd && picked;
		assign down[i].wr     = up.wr && picked;
		assign down[i].addr   = picked ? up.addr : '0;
		assign down[i].wdata  = picked ? up.wdata : '0;
	end

endmodule

/* source/cache_array.sv */
`timescale 1ns/1ps

module cache_array (
	input  logic    clk,
	input  logic    arst_n,
	cache_if.array  port
);
	import cache_pkg::*;

	tag_t                 tags [NUM_LINES];
	word_t                data [NUM_LINES][WORDS_PER_LINE];
	logic [NUM_LINES-1:0] valid_q;
	logic [NUM_LINES-1:0] dirty_q;
	logic                 tag_match;
	logic                 hit_wr;   // Processor write on a hit
	logic                 fill_wr;  // Refill word from memory

	assign tag_match       = (tags[port.index] == port.tag);
	assign port.valid      = valid_q[port.index];
	assign port.dirty      = dirty_q[port.index];
	assign port.hit        = port.enable && port.comp && port.valid && tag_match;
	assign port.rdata      = data[port.index][port.word_sel];
	assign port.victim_tag = tags[port.index];

	assign hit_wr  = port.hit && port.write;
	assign fill_wr = port.enable && !port.comp && port.write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (fill_wr) begin
				valid_q[port.index] <= 1'b1;
				dirty_q[port.index] <= 1'b0; // Fresh line matches memory
			end else if (hit_wr) begin
				dirty_q[port.index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit_wr || fill_wr)
			data[port.index][port.word_sel] <= port.wdata;
		if (fill_wr)
			tags[port.index] <= port.tag;
	end

endmodule

/* source/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
	input  logic              clk,
	input  logic              arst_n,
	input  cache_pkg::addr_t  addr,
	input  cache_pkg::word_t  data_in,
	input  logic              rd,
	input  logic              wr,
	output cache_pkg::word_t  data_out,
	output logic              done,
	output logic              hit,
	output logic              err,
	cache_if.ctrl             cache,
	mem_req_if.requester      mem,
	input  cache_pkg::word_t  fill_data,
	input  logic              fill_valid
);
	import cache_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;
	addr_t       addr_q;
	word_t       data_q;
	logic        wr_q;       // Latched operation, high for a write
	logic        miss_q;     // First compare missed
	word_sel_t   fill_cnt;   // Refill words returned so far
	word_sel_t   mem_wsel;
	logic        legal_req;
	logic        wb_phase;
	logic        fill_phase;

	assign legal_req  = rd ^ wr;
	assign wb_phase   = state inside {WB_0, WB_1, WB_2, WB_3};
	assign fill_phase = state inside {FILL_REQ_2_WR_0, FILL_REQ_3_WR_1, FILL_WR_2, FILL_WR_3};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE:            if (legal_req) state_nxt = COMPARE;
			COMPARE: begin
				if (cache.hit)
					state_nxt = DONE;
				else if (cache.valid && cache.dirty)
					state_nxt = WB_0;              // Victim must go back first
				else
					state_nxt = FILL_REQ_0;
			end
			WB_0:            state_nxt = WB_1;
			WB_1:            state_nxt = WB_2;
			WB_2:            state_nxt = WB_3;
			WB_3:            state_nxt = FILL_REQ_0;
			FILL_REQ_0:      state_nxt = FILL_REQ_1;
			FILL_REQ_1:      state_nxt = FILL_REQ_2_WR_0;
			FILL_REQ_2_WR_0: state_nxt = FILL_REQ_3_WR_1;
			FILL_REQ_3_WR_1: state_nxt = FILL_WR_2;
			FILL_WR_2:       state_nxt = FILL_WR_3;
			FILL_WR_3:       state_nxt = COMPARE; // Second lookup now hits
			DONE:            state_nxt = IDLE;
			default:         state_nxt = IDLE;
		endcase
	end

	// Cache and memory request decode
	always_comb begin
		cache.enable   = 1'b0;
		cache.comp     = 1'b0;
		cache.write    = 1'b0;
		cache.word_sel = addr_q[2:1];
		cache.wdata    = data_q;
		mem.rd         = 1'b0;
		mem.wr         = 1'b0;
		mem_wsel       = '0;
		case (state)
			COMPARE: begin
				cache.enable = 1'b1;
				cache.comp   = 1'b1;
				cache.write  = wr_q;
			end
			WB_0, WB_1, WB_2, WB_3: begin
				mem_wsel       = word_sel_t'(state - WB_0);
				cache.enable   = 1'b1;
				cache.word_sel = mem_wsel;    // Read victim word
				mem.wr         = 1'b1;
			end
			FILL_REQ_0, FILL_REQ_1, FILL_REQ_2_WR_0, FILL_REQ_3_WR_1: begin
				mem_wsel = word_sel_t'(state - FILL_REQ_0);
				mem.rd   = 1'b1;
			end
			default: ;
		endcase
		if (fill_phase) begin
			cache.enable   = fill_valid;
			cache.write    = fill_valid;
			cache.word_sel = fill_cnt;
			cache.wdata    = fill_data;
		end
	end

	assign cache.tag   = addr_q[15:8];
	assign cache.index = addr_q[7:3];

	// Write-back uses the stored tag, refill the requested one
	assign mem.addr  = {wb_phase ? cache.victim_tag : addr_q[15:8], addr_q[7:3], mem_wsel};
	assign mem.wdata = cache.rdata;

	always_ff @(posedge clk) begin
		if (state == IDLE && legal_req) begin
			addr_q <= addr;
			data_q <= data_in;
			wr_q   <= wr;
		end
		if (state == COMPARE && cache.hit)
			data_out <= wr_q ? data_q : cache.rdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			miss_q   <= 1'b0;
			fill_cnt <= '0;
			err      <= 1'b0;
		end else begin
			err <= (state == IDLE) && rd && wr;
			if (state == IDLE) begin
				miss_q   <= 1'b0;
				fill_cnt <= '0;
			end else if (state == COMPARE && !cache.hit) begin
				miss_q <= 1'b1;
			end
			if (fill_phase && fill_valid)
				fill_cnt <= fill_cnt + 1'b1;
		end
	end

	assign done = (state == DONE);
	assign hit  = done && !miss_q;

endmodule

/* source/cache_if.sv */
`timescale 1ns/1ps

interface cache_if;
	import cache_pkg::*;

	logic      enable;
	logic      comp;       // Compare access, else refill access
	logic      write;
	tag_t      tag;
	index_t    index;
	word_sel_t word_sel;
	word_t     wdata;
	word_t     rdata;
	logic      hit;
	logic      valid;
	logic      dirty;
	tag_t      victim_tag; // Stored tag of the indexed line

	modport ctrl (
		output enable, comp, write, tag, index, word_sel, wdata,
		input  rdata, hit, valid, dirty, victim_tag
	);

	modport array (
		input  enable, comp, write, tag, index, word_sel, wdata,
		output rdata, hit, valid, dirty, victim_tag
	);

endinterface

/* source/mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if;
	import cache_pkg::*;

	localparam int REQ_ADDR_W = $bits(bank_addr_t) + $bits(word_sel_t);

	logic                  rd;
	logic                  wr;
	logic [REQ_ADDR_W-1:0] addr;  // {tag, index, word select}
	word_t                 wdata;

	modport requester (
		output rd, wr, addr, wdata
	);

	modport memory (
		input rd, wr, addr, wdata
	);

endinterface

/* source/cache_pkg.sv */
package cache_pkg;

	// Address split: tag [15:8], index [7:3], byte offset [2:0]
	localparam int WORD_W         = 16;
	localparam int ADDR_W         = 16;
	localparam int TAG_W          = 8;
	localparam int INDEX_W        = 5;
	localparam int WSEL_W         = 2;
	localparam int NUM_LINES      = 2 ** INDEX_W;
	localparam int WORDS_PER_LINE = 2 ** WSEL_W;

	localparam int NUM_BANKS   = 4; // One bank per word of a line
	localparam int MEM_LATENCY = 2; // Read strobe to rvalid

	typedef logic [WORD_W-1:0]        word_t;
	typedef logic [ADDR_W-1:0]        addr_t;
	typedef logic [TAG_W-1:0]         tag_t;
	typedef logic [INDEX_W-1:0]       index_t;
	typedef logic [WSEL_W-1:0]        word_sel_t;
	typedef logic [TAG_W+INDEX_W-1:0] bank_addr_t; // Word address inside a bank

	// Order matters, the controller derives word selects from it
	typedef enum logic [3:0] {
		IDLE,
		COMPARE,
		WB_0,
		WB_1,
		WB_2,
		WB_3,
		FILL_REQ_0,
		FILL_REQ_1,
		FILL_REQ_2_WR_0,
		FILL_REQ_3_WR_1,
		FILL_WR_2,
		FILL_WR_3,
		DONE
	} ctrl_state_e;

endpackage
